// ==== src.f ====
source/mipsPkg.sv
source/aluPkg.sv
source/aluDecoder.sv
source/alu.sv
source/regFile.sv
source/programCounter.sv
source/controlUnit.sv
source/datapath.sv
source/cpuTop.sv
verification/cpuTop_sva.sv
verification/cpuTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --timing --assert
TOP = cpuTb
FILELIST = src.f
BUILD_DIR = obj_dir
PASS_MSG = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb
	import mipsPkg::*;
();

	localparam int DataWidth = 32;
	localparam logic [DataWidth-1:0] ResetPc = '0;
	localparam int MemWords = 256;
	// Last store of the program lands here
	localparam logic [DataWidth-1:0] DoneAddr = 32'h1fc;
	localparam int TimeoutCycles = 2000;

	logic cclk;
	logic rstb;
	logic [DataWidth-1:0] memRdata;
	logic [DataWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWdata;
	logic memWe;
	logic [31:0] mem [MemWords];
	logic runEnded;
	logic sawDone;
	int cycles;

	// I-format word
	function automatic logic [31:0] immWord(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// R-format word, shamt unused
	function automatic logic [31:0] regWord(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [25:0] target);
		return {OP_J, target};
	endfunction

	// Test program, word index = byte address / 4, rest of memory is NOP
	function automatic logic [31:0] programWord(input int idx);
		case (idx)
			0: return immWord(OP_ADDI, 5'd0, 5'd10, 16'h7bad);
			1: return immWord(OP_ADDI, 5'd0, 5'd1, 16'd7);
			2: return immWord(OP_ADDI, 5'd0, 5'd2, 16'hfffd);
			3: return regWord(5'd1, 5'd2, 5'd3, FN_ADD);
			4: return regWord(5'd1, 5'd2, 5'd4, FN_SUB);
			5: return regWord(5'd1, 5'd2, 5'd5, FN_AND);
			6: return regWord(5'd1, 5'd2, 5'd6, FN_OR);
			7: return regWord(5'd2, 5'd1, 5'd7, FN_SLT);
			// Results out to the data area at 0x100
			8: return immWord(OP_SW, 5'd0, 5'd1, 16'h100);
			9: return immWord(OP_SW, 5'd0, 5'd3, 16'h104);
			10: return immWord(OP_SW, 5'd0, 5'd4, 16'h108);
			11: return immWord(OP_SW, 5'd0, 5'd5, 16'h10c);
			12: return immWord(OP_SW, 5'd0, 5'd6, 16'h110);
			13: return immWord(OP_SW, 5'd0, 5'd7, 16'h114);
			// Load back the SUB result and store it again
			14: return immWord(OP_LW, 5'd0, 5'd8, 16'h108);
			15: return immWord(OP_SW, 5'd0, 5'd8, 16'h118);
			// Taken branch over a poisoned store
			16: return immWord(OP_BEQ, 5'd1, 5'd1, 16'd1);
			17: return immWord(OP_SW, 5'd0, 5'd10, 16'h11c);
			// Not taken, falls through to the store
			18: return immWord(OP_BEQ, 5'd1, 5'd2, 16'd1);
			19: return immWord(OP_SW, 5'd0, 5'd2, 16'h11c);
			20: return jumpWord(26'd22);
			21: return immWord(OP_SW, 5'd0, 5'd10, 16'h120);
			22: return immWord(OP_ADDI, 5'd0, 5'd11, 16'h600d);
			23: return immWord(OP_SW, 5'd0, 5'd11, 16'h1fc);
			// Spin in place
			24: return immWord(OP_BEQ, 5'd0, 5'd0, 16'hffff);
			default: return '0;
		endcase
	endfunction

	cpuTop #(.DataWidth(DataWidth), .ResetPc(ResetPc)) UUT (
		.cclk(cclk), .rstb(rstb), .memRdata(memRdata),
		.memAddr(memAddr), .memWdata(memWdata), .memWe(memWe)
	);

	// Unified memory, combinational read on the word index
	assign memRdata = mem[memAddr[9:2]];

	// Program reloads during reset, stores land on the clock edge
	always @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < MemWords; i++) begin
				mem[i[7:0]] <= programWord(i);
			end
		end else if (memWe) begin
			mem[memAddr[9:2]] <= memWdata;
		end
	end

	initial begin
		cclk = 1'b0;
		forever #5 cclk = ~cclk;
	end

	initial begin
		rstb = 1'b0;
		runEnded = 1'b0;
		sawDone = 1'b0;
		repeat (3) @(negedge cclk);
		rstb = 1'b1;
		// Run until the done store shows up on the bus
		for (cycles = 0; cycles < TimeoutCycles && !sawDone; cycles++) begin
			@(negedge cclk);
			if (memWe && memAddr == DoneAddr) begin
				sawDone = 1'b1;
			end
		end
		// Store commits, pulse checks sample
		repeat (2) @(negedge cclk);
		runEnded = 1'b1;
		if (sawDone) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "Program did not reach its done store within %0d cycles", TimeoutCycles);
		end
	end

	// Run cut short by a failed assertion
	final begin
		if (!runEnded) begin
			$display("Something failed");
			$fatal(1, "An assertion on the memory port stopped the run");
		end
	end

endmodule

// ==== verification/cpuTop_sva.sv ====
`timescale 1ns/1ps

module cpuTopSva #(
	parameter int DataWidth = 32,
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input logic cclk,
	input logic rstb,
	input logic [DataWidth-1:0] memAddr,
	input logic [DataWidth-1:0] memWdata,
	input logic memWe
);

	// Operands the program builds with ADDI
	localparam logic [DataWidth-1:0] OperandA = DataWidth'(7);
	localparam logic [DataWidth-1:0] OperandB = DataWidth'(-3);
	// Skipped stores would carry this
	localparam logic [DataWidth-1:0] PoisonValue = DataWidth'(32'h7bad);
	localparam logic [DataWidth-1:0] DoneMarker = DataWidth'(32'h600d);
	localparam logic [DataWidth-1:0] DataBase = DataWidth'(32'h100);
	localparam logic [DataWidth-1:0] DoneAddr = DataWidth'(32'h1fc);
	// Six results, the LW copy, the fall-through store
	localparam int StoresBeforeDone = 8;
	// MEM_WRITE of the first SW, counted from the first FETCH
	// Eight four-cycle ALU instructions come before it
	localparam int FirstStoreCycle = 35;

	int storeCount;
	int cycleCount;

	// Expected word per store address, anything else is wrong
	function automatic logic storeOk(input logic [DataWidth-1:0] addr,
			input logic [DataWidth-1:0] data);
		logic [DataWidth-1:0] expected;
		logic known;
		known = 1'b1;
		case (addr)
			DataBase: expected = OperandA;
			DataBase + 4: expected = OperandA + OperandB;
			DataBase + 8: expected = OperandA - OperandB;
			DataBase + 12: expected = OperandA & OperandB;
			DataBase + 16: expected = OperandA | OperandB;
			DataBase + 20: expected = ($signed(OperandB) < $signed(OperandA)) ? DataWidth'(1) : '0;
			// LW copy of the SUB result
			DataBase + 24: expected = OperandA - OperandB;
			// Not-taken BEQ stores rt of the compare
			DataBase + 28: expected = OperandB;
			DoneAddr: expected = DoneMarker;
			default: begin
				known = 1'b0;
				expected = '0;
			end
		endcase
		return known && (data == expected);
	endfunction

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			storeCount <= 0;
			cycleCount <= 0;
		end else begin
			cycleCount <= cycleCount + 1;
			if (memWe) begin
				storeCount <= storeCount + 1;
			end
		end
	end

	// Fetch starts at the reset vector
	firstFetch: assert property (@(posedge cclk) $rose(rstb) |-> memAddr == ResetPc)
		else $error("** Error %0t: first fetch address %h is not the reset PC", $time, memAddr);

	// Strobe low until the first SW reaches MEM_WRITE, high exactly then
	quietUntilFirstStore: assert property (@(posedge cclk) disable iff (!rstb)
		storeCount == 0 |-> memWe == (cycleCount == FirstStoreCycle))
		else $error("** Error %0t: write strobe is %b in cycle %0d, first store due in cycle %0d",
			$time, memWe, cycleCount, FirstStoreCycle);

	storeData: assert property (@(posedge cclk) disable iff (!rstb)
		memWe |-> storeOk(memAddr, memWdata))
		else $error("** Error %0t: store of %h to %h is not expected", $time, memWdata, memAddr);

	noPoison: assert property (@(posedge cclk) disable iff (!rstb)
		memWe |-> memWdata != PoisonValue)
		else $error("** Error %0t: skipped store executed at %h", $time, memAddr);

	// Strobe lasts one cycle
	oneCycleWe: assert property (@(posedge cclk) disable iff (!rstb) memWe |=> !memWe)
		else $error("** Error %0t: memory write strobe held for two cycles", $time);

	alignedWe: assert property (@(posedge cclk) disable iff (!rstb)
		memWe |-> memAddr[1:0] == 2'b00)
		else $error("** Error %0t: store to unaligned address %h", $time, memAddr);

	allStoresDone: assert property (@(posedge cclk) disable iff (!rstb)
		(memWe && memAddr == DoneAddr) |-> storeCount == StoresBeforeDone)
		else $error("** Error %0t: done store after %0d stores", $time, storeCount);

endmodule

// Memory port checks on every cpuTop
bind cpuTop cpuTopSva #(.DataWidth(DataWidth), .ResetPc(ResetPc)) memPortChecks (
	.cclk(cclk), .rstb(rstb), .memAddr(memAddr), .memWdata(memWdata), .memWe(memWe)
);

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop
	import mipsPkg::*;
	import aluPkg::*;
#(
	parameter int DataWidth = 32,
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input logic cclk,
	input logic rstb,
	input logic [DataWidth-1:0] memRdata,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWdata,
	output logic memWe
);

	logic [31:0] instr;
	logic IorD;
	logic MemtoReg;
	logic RegDst;
	logic ALUSrcA;
	srcBSelT ALUSrcB;
	pcSelT PCSrc;
	logic IRWrite;
	logic PCWrite;
	logic Branch;
	logic RegWrite;
	aluCtrlT ALUControl;
	logic [DataWidth-1:0] pc;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] aluOut;
	logic [DataWidth-1:0] jumpTarget;
	logic zero;

	// FSM
	controlUnit ctrl (
		.cclk(cclk), .rstb(rstb), .instr(instr),
		.IorD(IorD), .MemtoReg(MemtoReg), .RegDst(RegDst), .PCSrc(PCSrc),
		.ALUSrcA(ALUSrcA), .ALUSrcB(ALUSrcB), .IRWrite(IRWrite),
		.MemWrite(memWe), .PCWrite(PCWrite), .Branch(Branch),
		.RegWrite(RegWrite), .ALUControl(ALUControl)
	);

	programCounter #(.DataWidth(DataWidth), .ResetPc(ResetPc)) pcReg (
		.cclk(cclk), .rstb(rstb), .PCWrite(PCWrite), .Branch(Branch),
		.zero(zero), .PCSrc(PCSrc), .aluResult(aluResult), .aluOut(aluOut),
		.jumpTarget(jumpTarget), .pc(pc)
	);

	datapath #(.DataWidth(DataWidth)) dp (
		.cclk(cclk), .rstb(rstb), .IorD(IorD), .MemtoReg(MemtoReg),
		.RegDst(RegDst), .ALUSrcA(ALUSrcA), .ALUSrcB(ALUSrcB),
		.IRWrite(IRWrite), .RegWrite(RegWrite), .ALUControl(ALUControl),
		.pc(pc), .memRdata(memRdata), .instr(instr), .memAddr(memAddr),
		.memWdata(memWdata), .aluResult(aluResult), .aluOut(aluOut),
		.jumpTarget(jumpTarget), .zero(zero)
	);

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath
	import mipsPkg::*;
	import aluPkg::*;
#(
	parameter int DataWidth = 32
) (
	input logic cclk,
	input logic rstb,
	input logic IorD,
	input logic MemtoReg,
	input logic RegDst,
	input logic ALUSrcA,
	input srcBSelT ALUSrcB,
	input logic IRWrite,
	input logic RegWrite,
	input aluCtrlT ALUControl,
	input logic [DataWidth-1:0] pc,
	input logic [DataWidth-1:0] memRdata,
	output logic [31:0] instr,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWdata,
	output logic [DataWidth-1:0] aluResult,
	output logic [DataWidth-1:0] aluOut,
	output logic [DataWidth-1:0] jumpTarget,
	output logic zero
);

	logic [DataWidth-1:0] memData;
	logic [DataWidth-1:0] aReg;
	logic [DataWidth-1:0] bReg;
	logic [DataWidth-1:0] rdA;
	logic [DataWidth-1:0] rdB;
	logic [DataWidth-1:0] signImm;
	logic [DataWidth-1:0] srcA;
	logic [DataWidth-1:0] srcB;
	logic [4:0] writeAddr;
	logic [DataWidth-1:0] writeData;

	// Instruction word steers decode, so it is cleared
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			instr <= '0;
		end else if (IRWrite) begin
			instr <= memRdata[31:0];
		end
	end

	// Intermediate registers load every cycle
	always_ff @(posedge cclk) begin
		memData <= memRdata;
		aReg <= rdA;
		bReg <= rdB;
		aluOut <= aluResult;
	end

	assign signImm = {{(DataWidth-16){instr[15]}}, instr[15:0]};
	// Upper bits from PC+4, word index from instruction
	assign jumpTarget = {pc[DataWidth-1:28], instr[25:0], 2'b00};

	// rt for loads and ADDI, rd for R-type
	assign writeAddr = RegDst ? instr[15:11] : instr[20:16];
	assign writeData = MemtoReg ? memData : aluOut;

	regFile #(.DataWidth(DataWidth)) rf (
		.cclk(cclk),
		.readAddrA(instr[25:21]),
		.readAddrB(instr[20:16]),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.RegWrite(RegWrite),
		.readDataA(rdA),
		.readDataB(rdB)
	);

	// Operand muxes
	assign srcA = ALUSrcA ? aReg : pc;
	always_comb begin
		case (ALUSrcB)
			SRCB_FOUR: srcB = DataWidth'(4);
			SRCB_IMM: srcB = signImm;
			SRCB_IMMSHIFT: srcB = signImm << 2;
			default: srcB = bReg;
		endcase
	end

	alu #(.DataWidth(DataWidth)) aluInst (
		.srcA(srcA),
		.srcB(srcB),
		.ALUControl(ALUControl),
		.result(aluResult),
		.zero(zero)
	);

	// Fetch from PC, data access from ALUOut
	assign memAddr = IorD ? aluOut : pc;
	// Store data is rt
	assign memWdata = bReg;

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
	import mipsPkg::*;
	import aluPkg::*;
(
	input logic cclk,
	input logic rstb,
	input logic [31:0] instr,
	// Multiplexer selects
	output logic IorD,
	output logic MemtoReg,
	output logic RegDst,
	output pcSelT PCSrc,
	output logic ALUSrcA,
	output srcBSelT ALUSrcB,
	// Enables and strobes
	output logic IRWrite,
	output logic MemWrite,
	output logic PCWrite,
	output logic Branch,
	output logic RegWrite,
	output aluCtrlT ALUControl
);

	ctrlState state;
	ctrlState nextState;
	aluOpT ALUOp;
	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	aluDecoder aluDec (
		.ALUOp(ALUOp),
		.funct(funct),
		.ALUControl(ALUControl)
	);

	// State register, reset lands directly in FETCH
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	// Next state
	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				case (opcode)
					OP_LW, OP_SW: nextState = MEM_ADR;
					OP_RTYPE: nextState = EXECUTE;
					OP_BEQ: nextState = BRANCH;
					OP_ADDI: nextState = ITYPE_EXECUTE;
					OP_J: nextState = JUMP;
					// Unknown opcode just refetches
					default: nextState = FETCH;
				endcase
			end
			// Only loads and stores get here
			MEM_ADR: nextState = (opcode == OP_LW) ? MEM_READ : MEM_WRITE;
			MEM_READ: nextState = MEM_WRITEBACK;
			EXECUTE: nextState = ALU_WRITEBACK;
			ITYPE_EXECUTE: nextState = ITYPE_WRITEBACK;
			// Writebacks, stores, branch and jump all end the instruction
			default: nextState = FETCH;
		endcase
	end

	// Outputs decoded from the current state
	always_comb begin
		IorD = 1'b0;
		MemtoReg = 1'b0;
		RegDst = 1'b0;
		PCSrc = PC_ALU;
		ALUSrcA = 1'b0;
		ALUSrcB = SRCB_REG;
		IRWrite = 1'b0;
		MemWrite = 1'b0;
		PCWrite = 1'b0;
		Branch = 1'b0;
		RegWrite = 1'b0;
		ALUOp = ALUOP_ADD;
		case (state)
			FETCH: begin
				// Latch instruction, PC <= PC + 4
				ALUSrcB = SRCB_FOUR;
				IRWrite = 1'b1;
				PCWrite = 1'b1;
			end
			// Branch target precomputed into ALUOut
			DECODE: ALUSrcB = SRCB_IMMSHIFT;
			MEM_ADR, ITYPE_EXECUTE: begin
				ALUSrcA = 1'b1;
				ALUSrcB = SRCB_IMM;
			end
			MEM_READ: IorD = 1'b1;
			MEM_WRITEBACK: begin
				MemtoReg = 1'b1;
				RegWrite = 1'b1;
			end
			MEM_WRITE: begin
				IorD = 1'b1;
				MemWrite = 1'b1;
			end
			EXECUTE: begin
				ALUSrcA = 1'b1;
				ALUOp = ALUOP_FUNCT;
			end
			// rd destination for R-type
			ALU_WRITEBACK: begin
				RegDst = 1'b1;
				RegWrite = 1'b1;
			end
			BRANCH: begin
				// Compare A and B, take ALUOut on equal
				ALUSrcA = 1'b1;
				ALUOp = ALUOP_SUB;
				PCSrc = PC_ALUOUT;
				Branch = 1'b1;
			end
			// rt destination for ADDI
			ITYPE_WRITEBACK: RegWrite = 1'b1;
			JUMP: begin
				PCSrc = PC_JUMP;
				PCWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/programCounter.sv ====
`timescale 1ns/1ps

module programCounter
	import mipsPkg::*;
#(
	parameter int DataWidth = 32,
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input logic cclk,
	input logic rstb,
	input logic PCWrite,
	input logic Branch,
	input logic zero,
	input pcSelT PCSrc,
	input logic [DataWidth-1:0] aluResult,
	input logic [DataWidth-1:0] aluOut,
	input logic [DataWidth-1:0] jumpTarget,
	output logic [DataWidth-1:0] pc
);

	logic [DataWidth-1:0] pcNext;
	logic pcLoad;

	// Taken branch only when compare result is zero
	assign pcLoad = PCWrite | (Branch & zero);

	always_comb begin
		case (PCSrc)
			PC_ALUOUT: pcNext = aluOut;
			PC_JUMP: pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= ResetPc;
		end else if (pcLoad) begin
			pc <= pcNext;
		end
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
	parameter int DataWidth = 32
) (
	input logic cclk,
	input logic [4:0] readAddrA,
	input logic [4:0] readAddrB,
	input logic [4:0] writeAddr,
	input logic [DataWidth-1:0] writeData,
	input logic RegWrite,
	output logic [DataWidth-1:0] readDataA,
	output logic [DataWidth-1:0] readDataB
);

	logic [DataWidth-1:0] regs [32];

	// Asynchronous reads, $zero always reads as 0
	assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

	// Single write port, writes to $zero dropped
	always_ff @(posedge cclk) begin
		if (RegWrite && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
	import aluPkg::*;
#(
	parameter int DataWidth = 32
) (
	input logic [DataWidth-1:0] srcA,
	input logic [DataWidth-1:0] srcB,
	input aluCtrlT ALUControl,
	output logic [DataWidth-1:0] result,
	output logic zero
);

	logic lessThan;

	// Signed compare for SLT
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (ALUControl)
			ALU_AND: result = srcA & srcB;
			ALU_OR: result = srcA | srcB;
			ALU_SUB: result = srcA - srcB;
			// Result is 0 or 1
			ALU_SLT: result = {{(DataWidth-1){1'b0}}, lessThan};
			default: result = srcA + srcB;
		endcase
	end

	// Used by BEQ after a subtract
	assign zero = (result == '0);

endmodule

// ==== source/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder
	import mipsPkg::*;
	import aluPkg::*;
(
	input aluOpT ALUOp,
	input logic [5:0] funct,
	output aluCtrlT ALUControl
);

	always_comb begin
		case (ALUOp)
			ALUOP_ADD: ALUControl = ALU_ADD;
			ALUOP_SUB: ALUControl = ALU_SUB;
			default: begin
				// R-type, operation from funct
				case (funct)
					FN_ADD: ALUControl = ALU_ADD;
					FN_SUB: ALUControl = ALU_SUB;
					FN_AND: ALUControl = ALU_AND;
					FN_OR: ALUControl = ALU_OR;
					FN_SLT: ALUControl = ALU_SLT;
					// Unknown funct behaves as add
					default: ALUControl = ALU_ADD;
				endcase
			end
		endcase
	end

endmodule

// ==== source/aluPkg.sv ====
package aluPkg;

	// Four-bit ALU control, classic MIPS numbering
	typedef enum logic [3:0] {
		ALU_AND = 4'd0,
		ALU_OR = 4'd1,
		ALU_ADD = 4'd2,
		ALU_SUB = 4'd6,
		ALU_SLT = 4'd7
	} aluCtrlT;

	// Operation class from the controller
	// ADD for address and PC math, SUB for compare, FUNCT for R-type
	typedef enum logic [1:0] {
		ALUOP_ADD = 2'd0,
		ALUOP_SUB = 2'd1,
		ALUOP_FUNCT = 2'd2
	} aluOpT;

endpackage

// ==== source/mipsPkg.sv ====
package mipsPkg;

	// Opcodes of the supported subset
	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_J = 6'd2;
	localparam logic [5:0] OP_BEQ = 6'd4;
	localparam logic [5:0] OP_ADDI = 6'd8;
	localparam logic [5:0] OP_LW = 6'd35;
	localparam logic [5:0] OP_SW = 6'd43;

	// R-type funct field values
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// Controller states, one cycle each
	typedef enum logic [3:0] {
		FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WRITEBACK, MEM_WRITE,
		EXECUTE, ALU_WRITEBACK, BRANCH, ITYPE_EXECUTE, ITYPE_WRITEBACK, JUMP
	} ctrlState;

	// Second ALU operand source
	typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_IMMSHIFT} srcBSelT;

	// Next PC source
	typedef enum logic [1:0] {PC_ALU, PC_ALUOUT, PC_JUMP} pcSelT;

endpackage
